// ==== Bender.yml ====
package:
  name: cpu

export_include_dirs:
  - .

sources:
  - cpu_core_pkg.sv
  - cpu_isa_pkg.sv
  - cpu_fetch.sv
  - cpu_regfile.sv
  - cpu_execute.sv
  - cpu.sv
  - target: simulation
    files:
      - tb_cpu.sv

// ==== cpu.sv ====
`timescale 1ns/1ns

`include "cpu_params.svh"

module cpu
    import cpu_isa_pkg::*;
(
    input  logic                       clock,
    input  logic                       reset,

    // single-port memory, rw high reads and rw low writes
    input  logic [`CPU_DATA_WIDTH-1:0] data_in,
    output logic [`CPU_DATA_WIDTH-1:0] data_out,
    output logic [`CPU_ADDR_WIDTH-1:0] address,
    output logic                       rw
);

    instr_u                          instruction;
    logic                            execute_phase;
    logic                            jump_taken;
    logic [`CPU_ADDR_WIDTH-1:0]      jump_target;
    logic                            store_active;
    logic [`CPU_ADDR_WIDTH-1:0]      store_address;

    logic [`CPU_REG_INDEX_WIDTH-1:0] read_a_index;
    logic [`CPU_REG_INDEX_WIDTH-1:0] read_b_index;
    logic [`CPU_REG_INDEX_WIDTH-1:0] flag_index;
    logic [`CPU_DATA_WIDTH-1:0]      read_a_data;
    logic [`CPU_DATA_WIDTH-1:0]      read_b_data;
    logic                            flag_data;
    logic                            write_enable;
    logic [`CPU_REG_INDEX_WIDTH-1:0] write_index;
    logic [`CPU_DATA_WIDTH-1:0]      write_data;
    logic                            write_flag;

    cpu_fetch i_fetch (
        .clock         (clock),
        .reset         (reset),
        .data_in       (data_in),
        .jump_taken    (jump_taken),
        .jump_target   (jump_target),
        .store_active  (store_active),
        .store_address (store_address),
        .instruction   (instruction),
        .execute_phase (execute_phase),
        .address       (address),
        .rw            (rw)
    );

    cpu_regfile i_regfile (
        .clock        (clock),
        .reset        (reset),
        .read_a_index (read_a_index),
        .read_b_index (read_b_index),
        .flag_index   (flag_index),
        .read_a_data  (read_a_data),
        .read_b_data  (read_b_data),
        .flag_data    (flag_data),
        .write_enable (write_enable),
        .write_index  (write_index),
        .write_data   (write_data),
        .write_flag   (write_flag)
    );

    cpu_execute i_execute (
        .instruction   (instruction),
        .execute_phase (execute_phase),
        .read_a_index  (read_a_index),
        .read_b_index  (read_b_index),
        .flag_index    (flag_index),
        .read_a_data   (read_a_data),
        .read_b_data   (read_b_data),
        .flag_data     (flag_data),
        .write_enable  (write_enable),
        .write_index   (write_index),
        .write_data    (write_data),
        .write_flag    (write_flag),
        .jump_taken    (jump_taken),
        .jump_target   (jump_target),
        .store_active  (store_active),
        .store_address (store_address),
        .data_out      (data_out)
    );

endmodule

// ==== cpu_core_pkg.sv ====
package cpu_core_pkg;

    // every instruction spends one cycle in each state, in this order
    //
    // FETCH    address bus carries the pc, memory samples it
    // LATCH    memory returns the word, the instruction register takes it
    // EXECUTE  writeback, store and pc update all land at the end
    typedef enum logic [1:0] {
        FETCH   = 2'd0,
        LATCH   = 2'd1,
        EXECUTE = 2'd2
    } cycle_state_e;

endpackage

// ==== cpu_execute.sv ====
`timescale 1ns/1ns

`include "cpu_params.svh"

module cpu_execute
    import cpu_isa_pkg::*;
(
    input  instr_u                          instruction,
    input  logic                            execute_phase,

    // register file read side
    output logic [`CPU_REG_INDEX_WIDTH-1:0] read_a_index,
    output logic [`CPU_REG_INDEX_WIDTH-1:0] read_b_index,
    output logic [`CPU_REG_INDEX_WIDTH-1:0] flag_index,
    input  logic [`CPU_DATA_WIDTH-1:0]      read_a_data,
    input  logic [`CPU_DATA_WIDTH-1:0]      read_b_data,
    input  logic                            flag_data,

    // register file write side
    output logic                            write_enable,
    output logic [`CPU_REG_INDEX_WIDTH-1:0] write_index,
    output logic [`CPU_DATA_WIDTH-1:0]      write_data,
    output logic                            write_flag,

    // control back to the sequencer
    output logic                            jump_taken,
    output logic [`CPU_ADDR_WIDTH-1:0]      jump_target,
    output logic                            store_active,
    output logic [`CPU_ADDR_WIDTH-1:0]      store_address,

    output logic [`CPU_DATA_WIDTH-1:0]      data_out
);

    alu_instr_t                 alu;
    jump_instr_t                jmp;
    opcode_e                    opcode;
    logic [`CPU_DATA_WIDTH:0]   sum;
    logic [`CPU_DATA_WIDTH:0]   diff;
    logic [`CPU_DATA_WIDTH-1:0] imm;
    logic                       less;
    logic [`CPU_DATA_WIDTH-1:0] result;
    logic                       result_flag;
    logic                       writes_reg;

    assign alu    = instruction.alu;
    assign jmp    = instruction.jump;
    // opcode sits in the same bits in both forms
    assign opcode = alu.opcode;

    assign read_a_index = alu.src_a;
    assign read_b_index = alu.src_b;
    assign flag_index   = jmp.flag_sel;

    // top bit of each extended result is the carry or the borrow
    assign sum  = {1'b0, read_a_data} + {1'b0, read_b_data};
    assign diff = {1'b0, read_a_data} - {1'b0, read_b_data};
    assign less = (read_a_data < read_b_data);

    // highlow puts the immediate in the upper half
    assign imm = alu.highlow ? {alu.value, {`CPU_IMM_WIDTH{1'b0}}}
                             : {{`CPU_IMM_WIDTH{1'b0}}, alu.value};

    always_comb
    begin
        result      = '0;
        result_flag = 1'b0;
        writes_reg  = 1'b1;
        case (opcode)
            ADD:
            begin
                result      = sum[`CPU_DATA_WIDTH-1:0];
                result_flag = sum[`CPU_DATA_WIDTH];
            end
            SUB:
            begin
                result      = diff[`CPU_DATA_WIDTH-1:0];
                result_flag = diff[`CPU_DATA_WIDTH];
            end
            AND:
            begin
                result      = read_a_data & read_b_data;
                result_flag = (result == '0);
            end
            OR:
            begin
                result      = read_a_data | read_b_data;
                result_flag = (result == '0);
            end
            XOR:
            begin
                result      = read_a_data ^ read_b_data;
                result_flag = (result == '0);
            end
            LOADI:  result = imm;
            CMPLT:
            begin
                result      = {{(`CPU_DATA_WIDTH-1){1'b0}}, less};
                result_flag = less;
            end
            // NOP, STORE and both jumps leave the registers alone
            default: writes_reg = 1'b0;
        endcase
    end

    assign write_enable = execute_phase & writes_reg;
    assign write_index  = alu.dest;
    assign write_data   = result;
    assign write_flag   = result_flag;

    assign jump_taken  = execute_phase &
                         ((opcode == JUMP) | ((opcode == JUMPF) & flag_data));
    assign jump_target = {{(`CPU_ADDR_WIDTH-`CPU_TARGET_WIDTH){1'b0}}, jmp.target};

    // store writes register a to the address in register b
    assign store_active  = execute_phase & (opcode == STORE);
    assign store_address = read_b_data;
    assign data_out      = store_active ? read_a_data : '0;

endmodule

// ==== cpu_fetch.sv ====
`timescale 1ns/1ns

`include "cpu_params.svh"

module cpu_fetch
    import cpu_isa_pkg::*;
    import cpu_core_pkg::*;
(
    input  logic                       clock,
    input  logic                       reset,

    // memory read data, one cycle after the address
    input  logic [`CPU_DATA_WIDTH-1:0] data_in,

    // redirect and store requests from the execute unit
    input  logic                       jump_taken,
    input  logic [`CPU_ADDR_WIDTH-1:0] jump_target,
    input  logic                       store_active,
    input  logic [`CPU_ADDR_WIDTH-1:0] store_address,

    output instr_u                     instruction,
    output logic                       execute_phase,

    // memory address and direction, rw high is a read
    output logic [`CPU_ADDR_WIDTH-1:0] address,
    output logic                       rw
);

    cycle_state_e               state;
    cycle_state_e               state_next;
    logic [`CPU_ADDR_WIDTH-1:0] pc;
    logic [`CPU_ADDR_WIDTH-1:0] pc_next;

    // fixed three-step rotation, nothing ever stalls it
    always_comb
    begin
        case (state)
            FETCH:   state_next = LATCH;
            LATCH:   state_next = EXECUTE;
            EXECUTE: state_next = FETCH;
            default: state_next = FETCH;
        endcase
    end

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            state <= FETCH;
        end
        else
        begin
            state <= state_next;
        end
    end

    // word arriving during LATCH belongs to the address of the last FETCH
    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            instruction <= '0;
        end
        else if (state == LATCH)
        begin
            instruction <= data_in;
        end
    end

    assign pc_next = jump_taken ? jump_target : pc + `CPU_ADDR_WIDTH'(1);

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            pc <= '0;
        end
        else if (state == EXECUTE)
        begin
            pc <= pc_next;
        end
    end

    assign execute_phase = (state == EXECUTE);

    // store_active only rises in EXECUTE, so the bus carries the pc otherwise
    assign address = store_active ? store_address : pc;
    assign rw      = ~store_active;

endmodule

// ==== cpu_isa_pkg.sv ====
package cpu_isa_pkg;

    `include "cpu_params.svh"

    // one opcode space shared by both instruction forms
    typedef enum logic [5:0] {
        NOP   = 6'd0,
        ADD   = 6'd1,
        SUB   = 6'd2,
        AND   = 6'd3,
        OR    = 6'd4,
        XOR   = 6'd5,
        LOADI = 6'd6,
        STORE = 6'd7,
        CMPLT = 6'd8,
        JUMP  = 6'd9,
        JUMPF = 6'd10
    } opcode_e;

    // register and immediate form, used by the ALU opcodes and STORE
    typedef struct packed {
        logic [`CPU_IMM_WIDTH-1:0]       value;
        logic                            highlow;
        logic [`CPU_REG_INDEX_WIDTH-1:0] dest;
        logic [`CPU_REG_INDEX_WIDTH-1:0] src_b;
        logic [`CPU_REG_INDEX_WIDTH-1:0] src_a;
        opcode_e                         opcode;
    } alu_instr_t;

    // control transfer form
    // flag_sel overlays src_a so the flag port and read port a share bits
    typedef struct packed {
        logic [`CPU_TARGET_WIDTH-1:0]    target;
        logic [`CPU_REG_INDEX_WIDTH-1:0] flag_sel;
        opcode_e                         opcode;
    } jump_instr_t;

    // the fetched word, viewed in whichever form its opcode calls for
    typedef union packed {
        alu_instr_t  alu;
        jump_instr_t jump;
    } instr_u;

endpackage

// ==== cpu_params.svh ====
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// width of the registers, the ALU and both memory data buses
`define CPU_DATA_WIDTH 32

// width of the memory address bus and of the program counter
`define CPU_ADDR_WIDTH 32

// number of general registers, each with its own flag
`define CPU_REG_COUNT 8

// bits needed to select one register
`define CPU_REG_INDEX_WIDTH 3

// immediate carried in the upper half of an ALU-form word
`define CPU_IMM_WIDTH 16

// jump target field of a jump-form word
`define CPU_TARGET_WIDTH 23

`endif

// ==== cpu_regfile.sv ====
`timescale 1ns/1ns

`include "cpu_params.svh"

module cpu_regfile (
    input  logic                           clock,
    input  logic                           reset,

    // two data read ports and one flag read port, all combinational
    input  logic [`CPU_REG_INDEX_WIDTH-1:0] read_a_index,
    input  logic [`CPU_REG_INDEX_WIDTH-1:0] read_b_index,
    input  logic [`CPU_REG_INDEX_WIDTH-1:0] flag_index,
    output logic [`CPU_DATA_WIDTH-1:0]      read_a_data,
    output logic [`CPU_DATA_WIDTH-1:0]      read_b_data,
    output logic                            flag_data,

    // register and its flag are written together
    input  logic                            write_enable,
    input  logic [`CPU_REG_INDEX_WIDTH-1:0] write_index,
    input  logic [`CPU_DATA_WIDTH-1:0]      write_data,
    input  logic                            write_flag
);

    logic [`CPU_DATA_WIDTH-1:0] regs  [`CPU_REG_COUNT];
    logic                       flags [`CPU_REG_COUNT];

    // the programs rely on a known all-zero register state after reset
    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            for (int i = 0; i < `CPU_REG_COUNT; i++)
            begin
                regs[i]  <= '0;
                flags[i] <= 1'b0;
            end
        end
        else if (write_enable)
        begin
            regs[write_index]  <= write_data;
            flags[write_index] <= write_flag;
        end
    end

    // no bypass, a write is seen by reads from the next cycle on
    assign read_a_data = regs[read_a_index];
    assign read_b_data = regs[read_b_index];
    assign flag_data   = flags[flag_index];

endmodule

// ==== files.f ====
+incdir+.
cpu_core_pkg.sv
cpu_isa_pkg.sv
cpu_fetch.sv
cpu_regfile.sv
cpu_execute.sv
cpu.sv
tb_cpu.sv

// ==== tb_cpu.sv ====
`timescale 1ns/1ns

`include "cpu_params.svh"

module tb_cpu
    import cpu_isa_pkg::*;
();

    localparam int MEM_DEPTH  = 256;
    localparam int MEM_BITS   = 8;
    localparam int MAX_ROWS   = 160;
    localparam int MAX_STORES = 64;
    localparam int RANDOM_OPS = 40;

    logic                       clock = 1'b0;
    logic                       reset = 1'b1;
    logic [`CPU_DATA_WIDTH-1:0] data_in = '0;
    logic [`CPU_DATA_WIDTH-1:0] data_out;
    logic [`CPU_ADDR_WIDTH-1:0] address;
    logic                       rw;

    // program table holding one row per executed instruction in execution order
    logic [31:0] row_word  [MAX_ROWS];
    logic [31:0] row_fetch [MAX_ROWS];
    logic        row_store [MAX_ROWS];
    logic [31:0] row_addr  [MAX_ROWS];
    logic [31:0] row_data  [MAX_ROWS];
    int          row_count = 0;
    int          directed_count = 0;

    logic [31:0] mem      [MEM_DEPTH];
    logic [31:0] log_addr [MAX_STORES];
    logic [31:0] log_data [MAX_STORES];
    int          store_count = 0;

    // register and flag state as the ISA defines it
    logic [31:0] ref_regs  [`CPU_REG_COUNT];
    logic        ref_flags [`CPU_REG_COUNT];

    logic [31:0] rng_state = 32'h6cdea8ad;
    int          cycle_count = 0;
    int          timeout_limit;

    cpu i_dut (
        .clock    (clock),
        .reset    (reset),
        .data_in  (data_in),
        .data_out (data_out),
        .address  (address),
        .rw       (rw)
    );

    initial
    begin
        forever #5 clock = ~clock;
    end

    // registered read with one cycle of latency
    // stores only go to the log
    always @(posedge clock)
    begin
        data_in <= mem[address[MEM_BITS-1:0]];
        if (rw === 1'b0 && store_count < MAX_STORES)
        begin
            log_addr[store_count] <= address;
            log_data[store_count] <= data_out;
            store_count           <= store_count + 1;
        end
    end

    always @(posedge clock)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_limit)
        begin
            $display("timeout: the program did not complete within %0d cycles", timeout_limit);
            $display("=== FAIL ===");
            $fatal(1);
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] alu_word(input opcode_e op, input logic [2:0] dest,
                                             input logic [2:0] src_a, input logic [2:0] src_b,
                                             input logic highlow, input logic [15:0] value);
        return {value, highlow, dest, src_b, src_a, op};
    endfunction

    function automatic logic [31:0] jump_word(input opcode_e op, input logic [2:0] flag_sel,
                                              input logic [22:0] target);
        return {target, flag_sel, op};
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input int row, input string what);
        if (actual !== expected)
        begin
            $display("[ERROR] %0t: row %0d %s: got %h, expected %h",
                     $time, row, what, actual, expected);
            $display("=== FAIL ===");
            $fatal(1);
        end
    endtask

    // applies one instruction to the model state
    task automatic ref_apply(input logic [31:0] word);
        logic [31:0] ra;
        logic [31:0] rb;
        logic [31:0] res;
        logic        flag;
        logic        writes;
        ra     = ref_regs[word[8:6]];
        rb     = ref_regs[word[11:9]];
        res    = '0;
        flag   = 1'b0;
        writes = 1'b1;
        case (word[5:0])
            ADD:
            begin
                res  = ra + rb;
                flag = (res < ra);
            end
            SUB:
            begin
                res  = ra - rb;
                flag = (ra < rb);
            end
            AND:
            begin
                res  = ra & rb;
                flag = (res == 0);
            end
            OR:
            begin
                res  = ra | rb;
                flag = (res == 0);
            end
            XOR:
            begin
                res  = ra ^ rb;
                flag = (res == 0);
            end
            LOADI:
            begin
                res = word[15] ? (32'(word[31:16]) << 16) : 32'(word[31:16]);
            end
            CMPLT:
            begin
                flag = (ra < rb);
                res  = 32'(flag);
            end
            default: writes = 1'b0;
        endcase
        if (writes)
        begin
            ref_regs[word[14:12]]  = res;
            ref_flags[word[14:12]] = flag;
        end
    endtask

    task automatic add_row(input logic [31:0] word, input logic [31:0] fetch,
                           input logic is_store, input logic [31:0] st_addr,
                           input logic [31:0] st_data);
        row_word[row_count]  = word;
        row_fetch[row_count] = fetch;
        row_store[row_count] = is_store;
        row_addr[row_count]  = st_addr;
        row_data[row_count]  = st_data;
        row_count++;
        ref_apply(word);
    endtask

    // loads, carry and borrow branches, untaken branches and plain jumps
    task automatic load_directed();
        add_row(alu_word(LOADI, 3'd1, 3'd0, 3'd0, 1'b0, 16'h1234), 0, 1'b0, 0, 0);
        add_row(alu_word(STORE, 3'd0, 3'd1, 3'd0, 1'b0, 16'h0), 1, 1'b1, 0, 32'h0000_1234);
        add_row(alu_word(LOADI, 3'd2, 3'd0, 3'd0, 1'b1, 16'habcd), 2, 1'b0, 0, 0);
        add_row(alu_word(STORE, 3'd0, 3'd2, 3'd1, 1'b0, 16'h0), 3, 1'b1,
                32'h0000_1234, 32'habcd_0000);
        add_row(alu_word(LOADI, 3'd3, 3'd0, 3'd0, 1'b1, 16'hffff), 4, 1'b0, 0, 0);
        add_row(alu_word(ADD, 3'd4, 3'd3, 3'd2, 1'b0, 16'h0), 5, 1'b0, 0, 0);
        add_row(jump_word(JUMPF, 3'd4, 23'd20), 6, 1'b0, 0, 0);
        add_row(alu_word(STORE, 3'd0, 3'd4, 3'd1, 1'b0, 16'h0), 20, 1'b1,
                32'h0000_1234, 32'habcc_0000);
        add_row(alu_word(SUB, 3'd5, 3'd1, 3'd2, 1'b0, 16'h0), 21, 1'b0, 0, 0);
        add_row(jump_word(JUMPF, 3'd5, 23'd30), 22, 1'b0, 0, 0);
        add_row(alu_word(STORE, 3'd0, 3'd5, 3'd0, 1'b0, 16'h0), 30, 1'b1, 0, 32'h5433_1234);
        add_row(jump_word(JUMPF, 3'd1, 23'd50), 31, 1'b0, 0, 0);
        add_row(alu_word(ADD, 3'd6, 3'd1, 3'd1, 1'b0, 16'h0), 32, 1'b0, 0, 0);
        add_row(jump_word(JUMPF, 3'd6, 23'd60), 33, 1'b0, 0, 0);
        // target 56 puts 7 in the dest bits, so a stray write would hit r7
        add_row(jump_word(JUMP, 3'd0, 23'd56), 34, 1'b0, 0, 0);
        add_row(alu_word(STORE, 3'd0, 3'd7, 3'd0, 1'b0, 16'h0), 56, 1'b1, 0, 0);
        add_row(alu_word(AND, 3'd7, 3'd3, 3'd2, 1'b0, 16'h0), 57, 1'b0, 0, 0);
        add_row(alu_word(STORE, 3'd0, 3'd7, 3'd6, 1'b0, 16'h0), 58, 1'b1,
                32'h0000_2468, 32'habcd_0000);
        add_row(jump_word(JUMP, 3'd0, 23'd64), 59, 1'b0, 0, 0);
    endtask

    // each random ALU op is followed by a store of its destination
    // and by a branch on its flag
    task automatic build_random();
        logic [31:0] r;
        opcode_e     op;
        logic [2:0]  dest;
        logic [2:0]  src_sel;
        logic [31:0] fetch;
        fetch = 64;
        for (int i = 0; i < RANDOM_OPS; i++)
        begin
            rng_state = xorshift32(rng_state);
            r         = rng_state;
            case (r[2:0])
                3'd0:    op = ADD;
                3'd1:    op = SUB;
                3'd2:    op = AND;
                3'd3:    op = OR;
                3'd4:    op = XOR;
                3'd5:    op = CMPLT;
                default: op = LOADI;
            endcase
            dest    = r[5:3];
            src_sel = r[14:12];
            add_row(alu_word(op, dest, r[8:6], r[11:9], r[15], r[31:16]), fetch, 1'b0, 0, 0);
            fetch++;
            add_row(alu_word(STORE, 3'd0, dest, src_sel, 1'b0, 16'h0), fetch, 1'b1,
                    ref_regs[src_sel], ref_regs[dest]);
            fetch++;
            // a set flag skips the filler word right after the branch
            add_row(jump_word(JUMPF, dest, 23'(fetch + 2)), fetch, 1'b0, 0, 0);
            fetch = ref_flags[dest] ? fetch + 2 : fetch + 1;
        end
    endtask

    // one instruction slot sampled mid-cycle in FETCH, LATCH and EXECUTE
    task automatic run_slot(input int idx);
        @(negedge clock);
        check_value(address, row_fetch[idx], idx, "fetch address");
        check_value(rw, 1, idx, "rw in fetch");
        check_value(data_out, 0, idx, "data_out in fetch");
        @(negedge clock);
        check_value(rw, 1, idx, "rw in latch");
        check_value(data_out, 0, idx, "data_out in latch");
        @(negedge clock);
        if (row_store[idx])
        begin
            check_value(rw, 0, idx, "rw in store");
            check_value(address, row_addr[idx], idx, "store address");
            check_value(data_out, row_data[idx], idx, "store data");
        end
        else
        begin
            check_value(rw, 1, idx, "rw in execute");
            check_value(data_out, 0, idx, "data_out in execute");
        end
    endtask

    initial
    begin
        int k;
        // unused words decode as NOPs tagged with their own address
        for (int i = 0; i < MEM_DEPTH; i++)
        begin
            mem[i] = 32'(i) << 6;
        end
        for (int i = 0; i < `CPU_REG_COUNT; i++)
        begin
            ref_regs[i]  = '0;
            ref_flags[i] = 1'b0;
        end
        load_directed();
        directed_count = row_count;
        build_random();
        for (int i = 0; i < row_count; i++)
        begin
            mem[row_fetch[i][MEM_BITS-1:0]] = row_word[i];
        end
        timeout_limit = 3 * row_count + 50;

        repeat (10) @(posedge clock);
        reset <= 1'b0;

        for (int i = 0; i < directed_count; i++)
        begin
            run_slot(i);
        end
        for (int i = directed_count; i < row_count; i++)
        begin
            run_slot(i);
        end

        // the memory logs the last store on the following edge
        @(negedge clock);
        k = 0;
        for (int i = 0; i < row_count; i++)
        begin
            if (row_store[i])
            begin
                check_value(log_addr[k], row_addr[i], i, "logged store address");
                check_value(log_data[k], row_data[i], i, "logged store data");
                k++;
            end
        end
        check_value(store_count, k, row_count, "number of write cycles");

        $display("=== PASS ===");
        $finish;
    end

endmodule
